//--- sources.f
design/mac_frame_pkg.sv
design/mac_queue_pkg.sv
design/tx_stream_if.sv
design/tx_conf_sync.sv
design/tx_desc_decode.sv
design/tx_preamble_line.sv
design/tx_fcs_append.sv
design/mac_tx_gmii.sv
testbench/tb_mac_tx_gmii.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/1ps \
    --top-module tb_mac_tx_gmii \
    -Mdir obj_dir -o tb_mac_tx_gmii \
    -f sources.f

./obj_dir/tb_mac_tx_gmii > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- testbench/tb_mac_tx_gmii.sv
`timescale 1ns/1ps

module tb_mac_tx_gmii import mac_frame_pkg::*, mac_queue_pkg::*; ();

    localparam int CLK_PERIOD      = 100;
    localparam int NUM_FRAMES      = 40;
    // frames loaded together, priority is checked inside one batch
    localparam int BATCH           = 5;
    localparam int MAX_LEN         = 64;
    localparam int FRAME_BUDGET    = MAX_LEN + 13 + IFG_LEN + 20;
    // tag on at batch 2, off at 5, on again at 7
    localparam int NUM_CONF        = 3;
    localparam int CONF_CYCLES     = 24;
    localparam int BATCH_CYCLES    = BATCH * FRAME_BUDGET;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * FRAME_BUDGET + NUM_CONF * CONF_CYCLES + 60;

    logic  interface_clk;
    logic  rstn_mac;
    logic  desc_rd;
    desc_t desc_din;
    logic  desc_empty;
    logic  data_rd;
    byte_t data_din;
    logic  tdesc_rd;
    desc_t tdesc_din;
    logic  tdesc_empty;
    logic  tdata_rd;
    byte_t tdata_din;
    logic  mac_conf_valid;
    conf_t mac_conf_data;
    logic  mac_conf_resp;
    logic  gtx_dv;
    byte_t gtx_d;

    // fifo contents, best-effort and time-triggered
    desc_t      be_desc_q[$];
    desc_t      tt_desc_q[$];
    byte_t      be_data_q[$];
    byte_t      tt_data_q[$];
    // expected wire bytes and burst lengths in send order
    byte_t      exp_bytes[$];
    frame_len_t exp_lens[$];
    // bytes of the burst being collected
    byte_t      burst_q[$];
    int         frames_expected = 0;
    int         frames_seen     = 0;
    int         mismatch_cnt    = 0;
    int         protocol_cnt    = 0;

    mac_tx_gmii UUT (
        .interface_clk (interface_clk),
        .rstn_mac      (rstn_mac),
        .desc_rd       (desc_rd),
        .desc_din      (desc_din),
        .desc_empty    (desc_empty),
        .data_rd       (data_rd),
        .data_din      (data_din),
        .tdesc_rd      (tdesc_rd),
        .tdesc_din     (tdesc_din),
        .tdesc_empty   (tdesc_empty),
        .tdata_rd      (tdata_rd),
        .tdata_din     (tdata_din),
        .mac_conf_valid(mac_conf_valid),
        .mac_conf_data (mac_conf_data),
        .mac_conf_resp (mac_conf_resp),
        .gtx_dv        (gtx_dv),
        .gtx_d         (gtx_d)
    );

    initial begin
        interface_clk = 1'b0;
        forever #(CLK_PERIOD / 2) interface_clk = ~interface_clk;
    end

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (act !== exp) begin
            $display("Mismatch %s: expected 0x%02h, actual 0x%02h", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_len(input string name, input frame_len_t exp, input frame_len_t act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_conf(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %b, actual %b", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // 802.3 crc, one bit at a time, lsb first
    function automatic crc_t crc32_feed_byte(input crc_t crc_in, input byte_t d);
        crc_t c;
        logic fb;
        c = crc_in;
        for (int b = 0; b < 8; b++) begin
            fb = c[0] ^ d[b];
            c  = c >> 1;
            if (fb) begin
                c = c ^ CRC_POLY;
            end
        end
        return c;
    endfunction

    function automatic logic batch_uses_tag(input int b);
        return (b >= 2 && b < 5) || (b >= 7);
    endfunction

    // random frames into the fifos, expected bursts in arbitration order
    task automatic load_batch(input logic tag_on);
        frame_len_t len_a [BATCH];
        port_t      port_a [BATCH];
        logic       tt_a [BATCH];
        byte_t      data_a [BATCH][MAX_LEN];
        crc_t       crc;
        for (int f = 0; f < BATCH; f++) begin
            tt_a[f]   = 1'($urandom_range(1, 0));
            len_a[f]  = frame_len_t'($urandom_range(MAX_LEN, 1));
            port_a[f] = port_t'($urandom());
            for (int i = 0; i < MAX_LEN; i++) begin
                data_a[f][i] = byte_t'($urandom());
            end
        end
        // mid-cycle, so the fifo model sees the batch as one step
        @(negedge interface_clk);
        for (int f = 0; f < BATCH; f++) begin
            // payload goes in ahead of its descriptor
            for (int i = 0; i < int'(len_a[f]); i++) begin
                if (tt_a[f]) tt_data_q.push_back(data_a[f][i]);
                else be_data_q.push_back(data_a[f][i]);
            end
            if (tt_a[f]) tt_desc_q.push_back({port_a[f], len_a[f]});
            else be_desc_q.push_back({port_a[f], len_a[f]});
        end
        // time-triggered frames first, each queue in its own order
        for (int pass = 0; pass < 2; pass++) begin
            for (int f = 0; f < BATCH; f++) begin
                if (tt_a[f] == (pass == 0)) begin
                    crc = 32'hFFFFFFFF;
                    for (int i = 0; i < PREAMBLE_LEN; i++) begin
                        exp_bytes.push_back(PREAMBLE_BYTE);
                    end
                    exp_bytes.push_back(SFD_BYTE);
                    if (tag_on) begin
                        exp_bytes.push_back({4'h0, port_a[f]});
                        crc = crc32_feed_byte(crc, {4'h0, port_a[f]});
                    end
                    for (int i = 0; i < int'(len_a[f]); i++) begin
                        exp_bytes.push_back(data_a[f][i]);
                        crc = crc32_feed_byte(crc, data_a[f][i]);
                    end
                    crc = ~crc;
                    // fcs low byte first
                    for (int k = 0; k < 4; k++) begin
                        exp_bytes.push_back(crc[8*k +: 8]);
                    end
                    exp_lens.push_back(frame_len_t'(PREAMBLE_LEN + 1 + int'(tag_on)
                        + int'(len_a[f]) + 4));
                    frames_expected++;
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    task automatic wait_resp(input logic level, input string name);
        int n;
        n = 0;
        @(negedge interface_clk);
        while (mac_conf_resp !== level && n < 4) begin
            @(negedge interface_clk);
            n++;
        end
        check_conf(name, level, mac_conf_resp);
    endtask

    // full valid/resp exchange, upper config bits random
    task automatic conf_exchange(input logic tag_on);
        conf_t word;
        word    = conf_t'($urandom());
        word[0] = tag_on;
        @(posedge interface_clk);
        mac_conf_data  <= word;
        mac_conf_valid <= 1'b1;
        wait_resp(1'b1, "conf resp rise");
        @(posedge interface_clk);
        mac_conf_valid <= 1'b0;
        wait_resp(1'b0, "conf resp fall");
        repeat (2) @(posedge interface_clk);
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge interface_clk);
            if ((gtx_dv | desc_rd | tdesc_rd | data_rd | tdata_rd) !== 1'b0) begin
                $display("gtx_dv or a fifo read is active while both descriptor FIFOs are empty");
                protocol_cnt++;
            end
        end
    endtask

    task automatic wait_batch_done(input int batch, output bit ok);
        int n;
        n = 0;
        while (frames_seen < frames_expected && n < BATCH_CYCLES) begin
            @(posedge interface_clk);
            n++;
        end
        ok = (frames_seen >= frames_expected);
        if (!ok) begin
            $display("batch %0d: %0d expected frames were never sent", batch,
                frames_expected - frames_seen);
            protocol_cnt++;
        end
        repeat (IFG_LEN + 4) @(posedge interface_clk);
    endtask

    ////////////////////////////////////////////////////////////
    // fifo models and gmii monitor
    ////////////////////////////////////////////////////////////

    // registered read data, word valid the cycle after the strobe
    initial begin
        desc_din    <= '0;
        tdesc_din   <= '0;
        data_din    <= '0;
        tdata_din   <= '0;
        desc_empty  <= 1'b1;
        tdesc_empty <= 1'b1;
        forever begin
            @(posedge interface_clk);
            if (desc_rd === 1'b1) begin
                if (be_desc_q.size() == 0) begin
                    $display("descriptor read from the empty best-effort FIFO");
                    protocol_cnt++;
                end else desc_din <= be_desc_q.pop_front();
            end
            if (tdesc_rd === 1'b1) begin
                if (tt_desc_q.size() == 0) begin
                    $display("descriptor read from the empty time-triggered FIFO");
                    protocol_cnt++;
                end else tdesc_din <= tt_desc_q.pop_front();
            end
            if (data_rd === 1'b1 && be_data_q.size() > 0) data_din <= be_data_q.pop_front();
            if (tdata_rd === 1'b1 && tt_data_q.size() > 0) tdata_din <= tt_data_q.pop_front();
            desc_empty  <= (be_desc_q.size() == 0);
            tdesc_empty <= (tt_desc_q.size() == 0);
        end
    end

    task automatic compare_burst();
        frame_len_t exp_len;
        byte_t      exp_b;
        if (exp_lens.size() == 0) begin
            $display("burst of %0d bytes with no frame expected", burst_q.size());
            protocol_cnt++;
            return;
        end
        exp_len = exp_lens.pop_front();
        check_len($sformatf("frame %0d length", frames_seen), exp_len,
            frame_len_t'(burst_q.size()));
        for (int i = 0; i < int'(exp_len); i++) begin
            exp_b = exp_bytes.pop_front();
            if (i < burst_q.size()) begin
                check_byte($sformatf("frame %0d byte %0d", frames_seen, i), exp_b, burst_q[i]);
            end
        end
        frames_seen++;
    endtask

    // sampled mid-cycle, one burst per gtx_dv high run
    initial begin
        int gap;
        gap = 0;
        forever begin
            @(negedge interface_clk);
            if (gtx_dv === 1'b1) begin
                if (burst_q.size() == 0 && frames_seen > 0 && gap < IFG_LEN) begin
                    $display("gtx_dv rose again after %0d idle cycles, burst has a gap", gap);
                    protocol_cnt++;
                end
                burst_q.push_back(gtx_d);
                gap = 0;
            end else begin
                if (burst_q.size() > 0) begin
                    compare_burst();
                    burst_q.delete();
                end
                gap++;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge interface_clk);
        $display("run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("errors: %0d mismatches, %0d protocol", mismatch_cnt, protocol_cnt);
        $display("TEST FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic        tag_now;
        bit          batch_ok;
        void'($urandom(8));
        rstn_mac       <= 1'b0;
        mac_conf_valid <= 1'b0;
        mac_conf_data  <= '0;
        tag_now = 1'b0;
        repeat (3) @(posedge interface_clk);
        rstn_mac <= 1'b1;
        @(negedge interface_clk);
        check_conf("conf resp after reset", 1'b0, mac_conf_resp);
        check_idle(20);
        for (int b = 0; b < NUM_FRAMES / BATCH; b++) begin
            if (batch_uses_tag(b) != tag_now) begin
                tag_now = batch_uses_tag(b);
                conf_exchange(tag_now);
            end
            load_batch(tag_now);
            wait_batch_done(b, batch_ok);
            if (!batch_ok) begin
                break;
            end
        end
        $display("errors: %0d mismatches, %0d protocol", mismatch_cnt, protocol_cnt);
        if (mismatch_cnt == 0 && protocol_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- design/mac_tx_gmii.sv
`timescale 1ns/1ps

module mac_tx_gmii import mac_frame_pkg::*, mac_queue_pkg::*; (
    input  logic  interface_clk,
    input  logic  rstn_mac,
    // best-effort queue
    output logic  desc_rd,
    input  desc_t desc_din,
    input  logic  desc_empty,
    output logic  data_rd,
    input  byte_t data_din,
    // time-triggered queue
    output logic  tdesc_rd,
    input  desc_t tdesc_din,
    input  logic  tdesc_empty,
    output logic  tdata_rd,
    input  byte_t tdata_din,
    // config exchange
    input  logic  mac_conf_valid,
    input  conf_t mac_conf_data,
    output logic  mac_conf_resp,
    // gmii
    output logic  gtx_dv,
    output byte_t gtx_d
);

    logic  tag_enable;
    // preamble line head
    byte_t line_byte;
    logic  line_valid;
    logic  line_is_data;
    logic  line_last;

    tx_stream_if stream ();

    tx_conf_sync u_conf_sync (
        .interface_clk (interface_clk),
        .rstn_mac      (rstn_mac),
        .mac_conf_valid(mac_conf_valid),
        .mac_conf_data (mac_conf_data),
        .mac_conf_resp (mac_conf_resp),
        .tag_enable    (tag_enable)
    );

    tx_desc_decode u_desc_decode (
        .interface_clk(interface_clk),
        .rstn_mac     (rstn_mac),
        .desc_din     (desc_din),
        .tdesc_din    (tdesc_din),
        .desc_empty   (desc_empty),
        .tdesc_empty  (tdesc_empty),
        .desc_rd      (desc_rd),
        .tdesc_rd     (tdesc_rd),
        .data_din     (data_din),
        .tdata_din    (tdata_din),
        .data_rd      (data_rd),
        .tdata_rd     (tdata_rd),
        .tag_enable   (tag_enable),
        .stream       (stream.decode_mp)
    );

    tx_preamble_line u_preamble_line (
        .interface_clk(interface_clk),
        .rstn_mac     (rstn_mac),
        .stream       (stream.line_mp),
        .line_byte    (line_byte),
        .line_valid   (line_valid),
        .line_is_data (line_is_data),
        .line_last    (line_last)
    );

    tx_fcs_append u_fcs_append (
        .interface_clk(interface_clk),
        .rstn_mac     (rstn_mac),
        .line_byte    (line_byte),
        .line_valid   (line_valid),
        .line_is_data (line_is_data),
        .line_last    (line_last),
        .stream       (stream.fcs_mp),
        .gtx_dv       (gtx_dv),
        .gtx_d        (gtx_d)
    );

endmodule

//--- design/tx_fcs_append.sv
`timescale 1ns/1ps

module tx_fcs_append import mac_frame_pkg::*; (
    input  logic        interface_clk,
    input  logic        rstn_mac,
    input  byte_t       line_byte,
    input  logic        line_valid,
    input  logic        line_is_data,
    input  logic        line_last,
    tx_stream_if.fcs_mp stream,
    output logic        gtx_dv,
    output byte_t       gtx_d
);

    crc_t       crc_q;
    crc_t       fcs_word;
    // fcs byte phase
    logic       fcs_act;
    logic [1:0] fcs_cnt;
    logic       fcs_done;
    // inter-frame gap
    logic       ifg_act;
    logic [3:0] ifg_cnt;
    logic       ifg_done;

    // one byte of the lsb-first crc
    function automatic crc_t crc_step(input crc_t crc_in, input byte_t d);
        crc_t c;
        c = crc_in ^ {24'h000000, d};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

    assign fcs_word = ~crc_q;
    assign fcs_done = fcs_act && (fcs_cnt == 2'(FCS_LEN - 1));
    assign ifg_done = ifg_act && (ifg_cnt == 4'(IFG_LEN - 1));

    always_ff @(posedge interface_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            crc_q             <= CRC_INIT;
            fcs_act           <= 1'b0;
            fcs_cnt           <= 2'd0;
            ifg_act           <= 1'b0;
            ifg_cnt           <= 4'd0;
            gtx_dv            <= 1'b0;
            stream.frame_idle <= 1'b1;
        end else begin
            // preamble and sfd reseed, tag and data accumulate
            if (line_valid) begin
                crc_q <= line_is_data ? crc_step(crc_q, line_byte) : CRC_INIT;
            end
            gtx_dv <= line_valid || fcs_act;
            if (line_valid && line_last) begin
                fcs_act <= 1'b1;
            end else if (fcs_done) begin
                fcs_act <= 1'b0;
            end
            fcs_cnt <= fcs_act ? fcs_cnt + 2'd1 : 2'd0;
            // gap count starts with the last fcs byte
            if (fcs_done) begin
                ifg_act <= 1'b1;
                ifg_cnt <= 4'd0;
            end else if (ifg_act) begin
                ifg_cnt <= ifg_cnt + 4'd1;
                ifg_act <= !ifg_done;
            end
            if (stream.frame_start) begin
                stream.frame_idle <= 1'b0;
            end else if (ifg_done) begin
                stream.frame_idle <= 1'b1;
            end
        end
    end

    // gmii data, fcs sent low byte first
    always_ff @(posedge interface_clk) begin
        gtx_d <= fcs_act ? fcs_word[{fcs_cnt, 3'b000} +: 8] : line_byte;
    end

    // minimum gap between bursts on the wire
    assert property (@(posedge interface_clk) disable iff (!rstn_mac)
        $fell(gtx_dv) |-> !gtx_dv [*IFG_LEN]);

endmodule

//--- design/tx_preamble_line.sv
`timescale 1ns/1ps

module tx_preamble_line import mac_frame_pkg::*; (
    input  logic         interface_clk,
    input  logic         rstn_mac,
    tx_stream_if.line_mp stream,
    output byte_t        line_byte,
    output logic         line_valid,
    output logic         line_is_data,
    output logic         line_last
);

    // preamble, sfd and tag slot, head at entry 0
    byte_t                   line_q [PREAMBLE_LEN+2];
    // per-entry flags
    logic [PREAMBLE_LEN+1:0] vld_q;
    logic [PREAMBLE_LEN+1:0] cov_q;
    logic [PREAMBLE_LEN+1:0] lst_q;
    // occupied entries
    logic [3:0]              fill;
    // first free slot after this cycle's shift
    logic [3:0]              wr_idx;

    assign wr_idx = fill - {3'b000, vld_q[0]};

    ////////////////////////////////////////////////////////////
    // byte line
    ////////////////////////////////////////////////////////////

    always_ff @(posedge interface_clk) begin
        if (stream.frame_start) begin
            for (int i = 0; i < PREAMBLE_LEN; i++) begin
                line_q[i] <= PREAMBLE_BYTE;
            end
            line_q[PREAMBLE_LEN]   <= SFD_BYTE;
            // tag byte, high nibble zero
            line_q[PREAMBLE_LEN+1] <= {4'h0, stream.port};
        end else begin
            for (int i = 0; i < PREAMBLE_LEN + 1; i++) begin
                line_q[i] <= line_q[i+1];
            end
            // incoming byte lands right behind the last valid one
            if (stream.byte_valid) begin
                line_q[wr_idx] <= stream.byte_data;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // flags and fill count
    ////////////////////////////////////////////////////////////

    always_ff @(posedge interface_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            vld_q <= '0;
            cov_q <= '0;
            lst_q <= '0;
            fill  <= '0;
        end else if (stream.frame_start) begin
            // tag slot valid only when enabled
            vld_q <= {stream.tag_en, {(PREAMBLE_LEN + 1){1'b1}}};
            // crc starts at the tag
            cov_q <= {stream.tag_en, {(PREAMBLE_LEN + 1){1'b0}}};
            lst_q <= '0;
            fill  <= 4'(PREAMBLE_LEN + 1) + {3'b000, stream.tag_en};
        end else begin
            vld_q <= {1'b0, vld_q[PREAMBLE_LEN+1:1]};
            cov_q <= {1'b0, cov_q[PREAMBLE_LEN+1:1]};
            lst_q <= {1'b0, lst_q[PREAMBLE_LEN+1:1]};
            if (stream.byte_valid) begin
                vld_q[wr_idx] <= 1'b1;
                cov_q[wr_idx] <= 1'b1;
                lst_q[wr_idx] <= stream.last_byte;
            end
            fill <= wr_idx + {3'b000, stream.byte_valid};
        end
    end

    // head entry
    assign line_byte    = line_q[0];
    assign line_valid   = vld_q[0];
    assign line_is_data = cov_q[0];
    assign line_last    = lst_q[0];

    // fetched bytes must trail the preload with no gap
    assert property (@(posedge interface_clk) disable iff (!rstn_mac)
        stream.byte_valid |-> (fill != 4'd0));

endmodule

//--- design/tx_desc_decode.sv
`timescale 1ns/1ps

module tx_desc_decode import mac_frame_pkg::*, mac_queue_pkg::*; (
    input  logic           interface_clk,
    input  logic           rstn_mac,
    input  desc_t          desc_din,
    input  desc_t          tdesc_din,
    input  logic           desc_empty,
    input  logic           tdesc_empty,
    output logic           desc_rd,
    output logic           tdesc_rd,
    input  byte_t          data_din,
    input  byte_t          tdata_din,
    output logic           data_rd,
    output logic           tdata_rd,
    input  logic           tag_enable,
    tx_stream_if.decode_mp stream
);

    // one-hot, bit 0 idle, 1 desc read, 2 decode, 3 fetch
    logic [3:0] dec_state;
    logic [3:0] dec_state_next;
    // high for the time-triggered queue
    logic       arb_dir;
    logic       tag_q;
    // bytes still to read
    frame_len_t rem_cnt;
    logic       fetch_last;
    logic       desc_go;
    // read strobes delayed to match fifo latency
    logic       rd_q;
    logic       last_q;
    desc_t      desc_word;
    frame_len_t desc_len;
    port_t      desc_port;

    // one frame in flight, wait for the fcs stage
    assign desc_go    = stream.frame_idle && (!desc_empty || !tdesc_empty);
    assign fetch_last = (rem_cnt == frame_len_t'(1));

    always_comb begin
        case (dec_state)
            4'b0001: dec_state_next = desc_go ? 4'b0010 : 4'b0001;
            4'b0010: dec_state_next = 4'b0100;
            4'b0100: dec_state_next = 4'b1000;
            4'b1000: dec_state_next = fetch_last ? 4'b0001 : 4'b1000;
            default: dec_state_next = 4'b0001;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // arbitration and descriptor read
    ////////////////////////////////////////////////////////////

    always_ff @(posedge interface_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            dec_state <= 4'b0001;
            desc_rd   <= 1'b0;
            tdesc_rd  <= 1'b0;
            arb_dir   <= 1'b0;
            tag_q     <= 1'b0;
            rem_cnt   <= '0;
            rd_q      <= 1'b0;
            last_q    <= 1'b0;
        end else begin
            dec_state <= dec_state_next;
            // strict priority for time-triggered
            desc_rd   <= dec_state[0] && desc_go && tdesc_empty;
            tdesc_rd  <= dec_state[0] && desc_go && !tdesc_empty;
            // direction and tag frozen before frame_start
            if (dec_state[0] && desc_go) begin
                arb_dir <= !tdesc_empty;
                tag_q   <= tag_enable;
            end
            // length load, then count down per read
            if (dec_state[2]) begin
                rem_cnt <= desc_len;
            end else if (dec_state[3]) begin
                rem_cnt <= rem_cnt - 1'b1;
            end
            rd_q   <= data_rd || tdata_rd;
            last_q <= dec_state[3] && fetch_last;
        end
    end

    // descriptor word valid in the decode cycle
    assign desc_word = arb_dir ? tdesc_din : desc_din;
    assign desc_len  = desc_word[LEN_MSB:LEN_LSB];
    assign desc_port = desc_word[PORT_MSB:PORT_LSB];

    // byte read level for the whole fetch
    assign data_rd  = dec_state[3] && !arb_dir;
    assign tdata_rd = dec_state[3] && arb_dir;

    ////////////////////////////////////////////////////////////
    // stream towards the preamble line
    ////////////////////////////////////////////////////////////

    assign stream.frame_start = dec_state[2];
    assign stream.port        = desc_port;
    assign stream.tag_en      = tag_q;
    assign stream.byte_data   = arb_dir ? tdata_din : data_din;
    assign stream.byte_valid  = rd_q;
    assign stream.last_byte   = last_q;

    // one descriptor strobe, and only while the fcs stage is still idle
    assert property (@(posedge interface_clk) disable iff (!rstn_mac)
        (desc_rd || tdesc_rd) |-> (desc_rd != tdesc_rd) && stream.frame_idle);

    // only one byte fifo, and only after the fcs stage left idle
    assert property (@(posedge interface_clk) disable iff (!rstn_mac)
        (data_rd || tdata_rd) |-> (data_rd != tdata_rd) && !stream.frame_idle);

endmodule

//--- design/tx_conf_sync.sv
`timescale 1ns/1ps

module tx_conf_sync import mac_queue_pkg::*; (
    input  logic  interface_clk,
    input  logic  rstn_mac,
    input  logic  mac_conf_valid,
    input  conf_t mac_conf_data,
    output logic  mac_conf_resp,
    output logic  tag_enable
);

    // valid comes from a slow domain
    logic [1:0] valid_sync;
    // one-hot, bit 0 idle, bit 1 load, bit 2 hold
    logic [2:0] conf_state;
    logic [2:0] conf_state_next;
    conf_t      conf_reg;

    always_ff @(posedge interface_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            valid_sync <= 2'b00;
        end else begin
            valid_sync <= {valid_sync[0], mac_conf_valid};
        end
    end

    // a valid that drops during load goes straight back to idle
    always_comb begin
        case (conf_state)
            3'b001:  conf_state_next = valid_sync[1] ? 3'b010 : 3'b001;
            3'b010:  conf_state_next = valid_sync[1] ? 3'b100 : 3'b001;
            3'b100:  conf_state_next = valid_sync[1] ? 3'b100 : 3'b001;
            default: conf_state_next = 3'b001;
        endcase
    end

    always_ff @(posedge interface_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            conf_state <= 3'b001;
            conf_reg   <= '0;
        end else begin
            conf_state <= conf_state_next;
            // capture on the synced rise
            if (conf_state[0] && valid_sync[1]) begin
                conf_reg <= mac_conf_data;
            end
        end
    end

    // resp is the hold state, decode samples the tag between frames
    assign mac_conf_resp = conf_state[2];
    assign tag_enable    = conf_reg[CONF_TAG_BIT];

    // resp only rises while the synced valid is still high
    assert property (@(posedge interface_clk) disable iff (!rstn_mac)
        $rose(mac_conf_resp) |-> valid_sync[1]);

endmodule

//--- design/tx_stream_if.sv
`timescale 1ns/1ps

interface tx_stream_if import mac_frame_pkg::*, mac_queue_pkg::*; ();

    // frame control, one pulse per frame
    logic  frame_start;
    port_t port;
    logic  tag_en;
    // fetched payload
    logic  byte_valid;
    byte_t byte_data;
    logic  last_byte;
    // back from the fcs stage, high when a new frame may start
    logic  frame_idle;

    // descriptor fetch side
    modport decode_mp (
        output frame_start, port, tag_en,
        output byte_valid, byte_data, last_byte,
        input  frame_idle
    );

    // preamble line
    modport line_mp (
        input  frame_start, port, tag_en,
        input  byte_valid, byte_data, last_byte
    );

    // fcs and gmii register
    modport fcs_mp (
        input  frame_start,
        output frame_idle
    );

endinterface

//--- design/mac_queue_pkg.sv
package mac_queue_pkg;

    ////////////////////////////////////////////////////////////
    // descriptor and config words
    ////////////////////////////////////////////////////////////

    // one word per frame in the descriptor fifo
    typedef logic [15:0] desc_t;
    // byte count of one frame
    typedef logic [11:0] frame_len_t;
    // source port, goes into the tag byte
    typedef logic [3:0]  port_t;
    // config word from the slow exchange
    typedef logic [3:0]  conf_t;

    // length field
    localparam int LEN_LSB      = 0;
    localparam int LEN_MSB      = 11;
    // port field
    localparam int PORT_LSB     = 12;
    localparam int PORT_MSB     = 15;

    // config bit that turns the tag on
    localparam int CONF_TAG_BIT = 0;

endpackage

//--- design/mac_frame_pkg.sv
package mac_frame_pkg;

    ////////////////////////////////////////////////////////////
    // gmii octet and crc register
    ////////////////////////////////////////////////////////////

    // one byte on the 8-bit gmii bus
    typedef logic [7:0]  byte_t;
    // running fcs value
    typedef logic [31:0] crc_t;

    // frame start sequence
    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hD5;
    localparam int    PREAMBLE_LEN  = 7;

    ////////////////////////////////////////////////////////////
    // fcs and gap
    ////////////////////////////////////////////////////////////

    // 802.3 polynomial in lsb-first form
    localparam crc_t  CRC_POLY      = 32'hEDB88320;
    localparam crc_t  CRC_INIT      = 32'hFFFFFFFF;
    // fcs bytes appended per frame
    localparam int    FCS_LEN       = 4;

    // idle cycles after the last fcs byte
    localparam int    IFG_LEN       = 12;

endpackage
